// ==== compile.f ====
common/rv_pkg.sv
fetch/fetch_unit.sv
decode/reg_file.sv
decode/decode_unit.sv
execute/execute_unit.sv
memory/mem_access.sv
src/core_top.sv
tb/tb_clock.sv
tb/core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := core_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam logic [31:0] NOP_INSTR  = 32'h0000_0013;
    localparam int          IMEM_WORDS = 256;
    localparam int          WB_TIMEOUT = 200;

    logic              clk;
    logic              rst;
    rv_pkg::word_t     imem_addr;
    rv_pkg::word_t     imem_data;
    logic              wb_we;
    rv_pkg::reg_addr_t wb_addr;
    rv_pkg::word_t     wb_data;

    logic [31:0] imem [IMEM_WORDS];
    logic [29:0] prog_len = '0;

    // program and ordered writebacks filled before reset release
    logic [31:0] prog [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    string       exp_name [$];

    logic [15:0] lfsr_state = 16'd51980;
    // byte image of the two data words under test
    logic [7:0]  shadow [8];

    int cyc      = -1;
    int wb_count = 0;
    int first_wb = -1;

    tb_clock clock_i (.clk_o(clk), .rst_o(rst));

    core_top dut_i (
        .clk(clk), .rst(rst),
        .imem_data_i(imem_data), .imem_addr_o(imem_addr),
        .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    // same-cycle instruction memory with nop past the program
    assign imem_data = (imem_addr[31:2] < prog_len) ? imem[imem_addr[9:2]] : NOP_INSTR;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    // taps x^16 + x^14 + x^13 + x^11 stepped once per bit
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] pc_now();
        return prog.size() * 4;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic emit(input logic [31:0] instr);
        prog.push_back(instr);
    endtask

    task automatic expect_wb(input string name, input logic [4:0] rd, input logic [31:0] val);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
    endtask

    // lui then addi with gaps so any reader sits three slots later
    task automatic load_const(input string name, input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] up;
        up = (val + 32'h800) & 32'hffff_f000;
        emit(u_type(up[31:12], rd, rv_pkg::OP_LUI));
        emit(NOP_INSTR);
        emit(NOP_INSTR);
        emit(i_type(val[11:0], rd, 3'b000, rd, rv_pkg::OP_IMM));
        emit(NOP_INSTR);
        emit(NOP_INSTR);
        expect_wb({name, " lui"}, rd, up);
        expect_wb({name, " addi"}, rd, val);
    endtask

    task automatic alu_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input logic [4:0] rd, input logic [31:0] val);
        emit(r_type(f7, 5'd2, 5'd1, f3, rd));
        expect_wb(name, rd, val);
    endtask

    task automatic build_alu();
        logic [31:0] a, b;
        logic [4:0]  sh;
        b  = rand_word();
        a  = rand_word();
        // negative a and positive b make slt and sltu disagree
        a  = {1'b1, a[30:0]};
        // b[4] set keeps the shift amount away from zero
        b  = {1'b0, b[30:5], 1'b1, b[3:0]};
        sh = b[4:0];
        load_const("alu a", 5'd1, a);
        load_const("alu b", 5'd2, b);
        alu_op("add", 7'h00, 3'b000, 5'd3, a + b);
        alu_op("sub", 7'h20, 3'b000, 5'd4, a - b);
        alu_op("sll", 7'h00, 3'b001, 5'd5, a << sh);
        alu_op("slt", 7'h00, 3'b010, 5'd6, {31'b0, $signed(a) < $signed(b)});
        alu_op("sltu", 7'h00, 3'b011, 5'd7, {31'b0, a < b});
        alu_op("xor", 7'h00, 3'b100, 5'd8, a ^ b);
        alu_op("srl", 7'h00, 3'b101, 5'd9, a >> sh);
        alu_op("sra", 7'h20, 3'b101, 5'd10, $signed(a) >>> sh);
        alu_op("or", 7'h00, 3'b110, 5'd11, a | b);
        alu_op("and", 7'h00, 3'b111, 5'd12, a & b);
        // x0 destinations never reach the writeback port
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        emit(i_type(12'd7, 5'd1, 3'b000, 5'd0, rv_pkg::OP_IMM));
        emit(u_type(20'habcde, 5'd0, rv_pkg::OP_LUI));
    endtask

    task automatic build_jumps();
        logic [31:0] p;
        p = pc_now();
        emit(u_type(20'h12345, 5'd13, rv_pkg::OP_AUIPC));
        expect_wb("auipc", 5'd13, p + 32'h1234_5000);
        p = pc_now();
        emit(j_type(21'd12, 5'd14));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd15, rv_pkg::OP_IMM));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd15, rv_pkg::OP_IMM));
        emit(i_type(12'd3, 5'd0, 3'b000, 5'd16, rv_pkg::OP_IMM));
        expect_wb("jal link", 5'd14, p + 32'd4);
        expect_wb("jal target", 5'd16, 32'd3);

        // jalr clears bit 0 of the odd base and lands on p+36
        p = pc_now();
        load_const("jalr base", 5'd27, p + 32'd37);
        emit(i_type(12'd0, 5'd27, 3'b000, 5'd28, rv_pkg::OP_JALR));
        emit(i_type(12'd4, 5'd0, 3'b000, 5'd29, rv_pkg::OP_IMM));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd29, rv_pkg::OP_IMM));
        emit(i_type(12'd6, 5'd0, 3'b000, 5'd29, rv_pkg::OP_IMM));
        expect_wb("jalr link", 5'd28, p + 32'd28);
        expect_wb("jalr target", 5'd29, 32'd6);
    endtask

    task automatic build_branches();
        logic [31:0] neg, pos, va, vb;
        logic [4:0]  rs1, rs2;
        logic [2:0]  f3;
        int          id;
        string       name;
        neg = rand_word() | 32'h8000_0000;
        pos = rand_word() & 32'h7fff_ffff;
        id  = 1;
        load_const("branch neg", 5'd20, neg);
        load_const("branch pos", 5'd21, pos);
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int c = 0; c < 3; c++) begin
                rs1  = (c == 1) ? 5'd21 : 5'd20;
                rs2  = (c == 0) ? 5'd21 : 5'd20;
                va   = (c == 1) ? pos : neg;
                vb   = (c == 0) ? pos : neg;
                name = $sformatf("branch f3=%0d case %0d", f3, c);
                // marker at +4 retires only on fall-through and +8 always retires
                emit(b_type(13'd8, rs2, rs1, f3));
                emit(i_type(12'(id), 5'd0, 3'b000, 5'd25, rv_pkg::OP_IMM));
                emit(i_type(12'(id), 5'd0, 3'b000, 5'd26, rv_pkg::OP_IMM));
                if (!branch_taken(f3, va, vb)) begin
                    expect_wb({name, " fall-through"}, 5'd25, 32'(id));
                end
                expect_wb({name, " join"}, 5'd26, 32'(id));
                id++;
            end
        end
    endtask

    task automatic store_bytes(input logic [31:0] base, input logic [2:0] off,
                               input logic [2:0] f3, input logic [4:0] rs2,
                               input logic [31:0] data);
        logic [31:0] addr;
        int          n;
        addr = base + {29'b0, off};
        n    = (f3 == 3'b000) ? 1 : (f3 == 3'b001) ? 2 : 4;
        emit(s_type(addr[11:0], rs2, 5'd0, f3));
        for (int i = 0; i < n; i++) begin
            shadow[off + 3'(i)] = data[8*i +: 8];
        end
    endtask

    task automatic load_check(input string name, input logic [31:0] base,
                              input logic [2:0] off, input logic [2:0] f3,
                              input logic [4:0] rd);
        logic [31:0] addr, val;
        logic [7:0]  b;
        logic [15:0] h;
        addr = base + {29'b0, off};
        b    = shadow[off];
        h    = {shadow[off + 3'd1], shadow[off]};
        case (f3)
            3'b000:  val = {{24{b[7]}}, b};
            3'b001:  val = {{16{h[15]}}, h};
            3'b100:  val = {24'b0, b};
            3'b101:  val = {16'b0, h};
            default: val = {shadow[off + 3'd3], shadow[off + 3'd2], h};
        endcase
        emit(i_type(addr[11:0], 5'd0, f3, rd, rv_pkg::OP_LOAD));
        expect_wb(name, rd, val);
    endtask

    task automatic build_memory();
        logic [31:0] base, w0, w1, hw, bt;
        // second word must stay inside the data memory
        base = (rand_word() % (rv_pkg::DMEM_WORDS - 1)) * 4;
        w0   = rand_word();
        w1   = rand_word();
        hw   = rand_word() | 32'h0000_8000;
        bt   = rand_word() | 32'h0000_0080;
        load_const("store w0", 5'd5, w0);
        load_const("store w1", 5'd6, w1);
        load_const("store half", 5'd7, hw);
        load_const("store byte", 5'd8, bt);
        store_bytes(base, 3'd0, 3'b010, 5'd5, w0);
        store_bytes(base, 3'd4, 3'b010, 5'd6, w1);
        store_bytes(base, 3'd6, 3'b001, 5'd7, hw);
        store_bytes(base, 3'd1, 3'b000, 5'd8, bt);
        load_check("lw low", base, 3'd0, 3'b010, 5'd9);
        load_check("lw high", base, 3'd4, 3'b010, 5'd10);
        load_check("lh", base, 3'd6, 3'b001, 5'd11);
        load_check("lhu", base, 3'd6, 3'b101, 5'd12);
        load_check("lh low", base, 3'd0, 3'b001, 5'd13);
        load_check("lb", base, 3'd1, 3'b000, 5'd14);
        load_check("lbu", base, 3'd1, 3'b100, 5'd15);
        load_check("lbu top", base, 3'd3, 3'b100, 5'd16);
        load_check("lb upper word", base, 3'd5, 3'b000, 5'd17);
    endtask

    task automatic wait_wb(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (wb_we !== 1'b1) begin
            if (n == WB_TIMEOUT) begin
                fail_run($sformatf("timeout: no writeback for %s in %0d cycles",
                                   name, WB_TIMEOUT));
            end
            n++;
            @(negedge clk);
        end
    endtask

    // writeback monitor counting cycle 0 as the first cycle out of reset
    always @(negedge clk) begin
        if (rst) begin
            cyc = -1;
        end else begin
            cyc = cyc + 1;
            if (wb_we) begin
                wb_count = wb_count + 1;
                if (first_wb < 0) begin
                    first_wb = cyc;
                end
            end
        end
    end

    initial begin
        int n;
        build_alu();
        build_jumps();
        build_branches();
        build_memory();
        if (prog.size() > IMEM_WORDS) begin
            fail_run("program does not fit in the instruction memory");
        end
        for (int i = 0; i < prog.size(); i++) begin
            imem[i[7:0]] = prog[i];
        end
        prog_len = 30'(prog.size());

        n = 0;
        while (rst !== 1'b0) begin
            if (n == 20) begin
                fail_run("reset was never released");
            end
            n++;
            @(negedge clk);
        end

        for (int i = 0; i < exp_rd.size(); i++) begin
            wait_wb(exp_name[i]);
            check_value({exp_name[i], " addr"}, 32'(exp_rd[i]), 32'(wb_addr));
            check_value({exp_name[i], " data"}, exp_val[i], wb_data);
        end

        // the nop tail must not write back
        n = 0;
        while (n < 20) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        check_value("writeback count", exp_rd.size(), wb_count);
        check_value("first writeback cycle", 32'd4, first_wb);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset covers the first three rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== src/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire               clk,
    input  wire               rst,
    input  rv_pkg::word_t     imem_data_i,
    output rv_pkg::word_t     imem_addr_o,
    output logic              wb_we_o,
    output rv_pkg::reg_addr_t wb_addr_o,
    output rv_pkg::word_t     wb_data_o
);

    // fetch -> decode
    rv_pkg::word_t     fd_instr, fd_pc;
    logic              fd_valid;

    // register file reads
    rv_pkg::reg_addr_t rs1_addr, rs2_addr;
    rv_pkg::word_t     rs1_data, rs2_data;

    // decode -> execute
    rv_pkg::opcode_t   de_op;
    rv_pkg::funct3_t   de_funct3;
    logic              de_alt, de_dest_we, de_valid;
    rv_pkg::word_t     de_a, de_b, de_store_data, de_target;
    rv_pkg::reg_addr_t de_dest_addr;

    // execute -> fetch/decode and memory
    logic              redirect;
    rv_pkg::word_t     redirect_pc;
    rv_pkg::word_t     em_result, em_wdata;
    rv_pkg::reg_addr_t em_dest_addr;
    logic              em_dest_we;
    rv_pkg::mem_req_t  em_req;

    fetch_unit fetch_i (
        .clk(clk), .rst(rst),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o),
        .instr_o(fd_instr), .pc_o(fd_pc), .valid_o(fd_valid)
    );

    reg_file rf_i (
        .clk(clk), .rst(rst),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .we_i(wb_we_o), .wd_addr_i(wb_addr_o), .wd_data_i(wb_data_o),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    decode_unit decode_i (
        .clk(clk), .rst(rst),
        .instr_i(fd_instr), .pc_i(fd_pc), .valid_i(fd_valid), .flush_i(redirect),
        .rf_rs1_data_i(rs1_data), .rf_rs2_data_i(rs2_data),
        .rf_rs1_addr_o(rs1_addr), .rf_rs2_addr_o(rs2_addr),
        .op_o(de_op), .funct3_o(de_funct3), .alt_o(de_alt),
        .operand_a_o(de_a), .operand_b_o(de_b), .store_data_o(de_store_data),
        .target_o(de_target), .dest_addr_o(de_dest_addr), .dest_we_o(de_dest_we),
        .valid_o(de_valid)
    );

    execute_unit execute_i (
        .clk(clk), .rst(rst),
        .op_i(de_op), .funct3_i(de_funct3), .alt_i(de_alt),
        .operand_a_i(de_a), .operand_b_i(de_b), .store_data_i(de_store_data),
        .target_i(de_target), .dest_addr_i(de_dest_addr), .dest_we_i(de_dest_we),
        .valid_i(de_valid),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .result_o(em_result), .dest_addr_o(em_dest_addr), .dest_we_o(em_dest_we),
        .mem_req_o(em_req), .mem_wdata_o(em_wdata)
    );

    mem_access mem_i (
        .clk(clk), .rst(rst),
        .result_i(em_result), .dest_addr_i(em_dest_addr), .dest_we_i(em_dest_we),
        .mem_req_i(em_req), .mem_wdata_i(em_wdata),
        .wb_we_o(wb_we_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
    );

endmodule

`default_nettype wire

// ==== memory/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    input  wire               clk,
    input  wire               rst,
    input  rv_pkg::word_t     result_i,
    input  rv_pkg::reg_addr_t dest_addr_i,
    input  wire               dest_we_i,
    input  rv_pkg::mem_req_t  mem_req_i,
    input  rv_pkg::word_t     mem_wdata_i,
    output logic              wb_we_o,
    output rv_pkg::reg_addr_t wb_addr_o,
    output rv_pkg::word_t     wb_data_o
);

    rv_pkg::word_t dmem [rv_pkg::DMEM_WORDS];

    logic [rv_pkg::DMEM_ADDR_W-1:0] idx;
    logic [1:0]    off, len;
    logic          en, wr, uns;
    logic [3:0]    be;
    rv_pkg::word_t wdata_sh, rdata_sh, load_val;

    assign idx = result_i[rv_pkg::DMEM_ADDR_W+1:2];
    assign off = result_i[1:0];
    assign en  = mem_req_i[rv_pkg::MEM_EN_BIT];
    assign wr  = mem_req_i[rv_pkg::MEM_WR_BIT];
    assign uns = mem_req_i[rv_pkg::MEM_UNS_BIT];
    assign len = mem_req_i[rv_pkg::MEM_LEN_LSB +: 2];

    // byte lanes touched by a store
    assign be = (len == rv_pkg::MEM_LEN_BYTE) ? (4'b0001 << off) :
                (len == rv_pkg::MEM_LEN_HALF) ? (4'b0011 << off) : 4'b1111;
    assign wdata_sh = mem_wdata_i << {off, 3'b000};

    always_ff @(posedge clk) begin
        if (en && wr) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    dmem[idx][8*i +: 8] <= wdata_sh[8*i +: 8];
                end
            end
        end
    end

    assign rdata_sh = dmem[idx] >> {off, 3'b000};

    always_comb begin
        case (len)
            rv_pkg::MEM_LEN_BYTE: load_val = {{24{!uns && rdata_sh[7]}}, rdata_sh[7:0]};
            rv_pkg::MEM_LEN_HALF: load_val = {{16{!uns && rdata_sh[15]}}, rdata_sh[15:0]};
            default:              load_val = rdata_sh;
        endcase
    end

    // memory/writeback register
    always_ff @(posedge clk) begin
        wb_addr_o <= dest_addr_i;
        wb_data_o <= (en && !wr) ? load_val : result_i;
        if (rst) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= dest_we_i && dest_addr_i != '0;
        end
    end

    // address comes from execute, size from the decoded funct3
    assert property (@(posedge clk) disable iff (rst)
        en |-> ((len == rv_pkg::MEM_LEN_WORD) ? off == 2'b00 :
                (len == rv_pkg::MEM_LEN_HALF) ? !off[0] : 1'b1));

endmodule

`default_nettype wire

// ==== execute/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire               clk,
    input  wire               rst,
    input  rv_pkg::opcode_t   op_i,
    input  rv_pkg::funct3_t   funct3_i,
    input  wire               alt_i,
    input  rv_pkg::word_t     operand_a_i,
    input  rv_pkg::word_t     operand_b_i,
    input  rv_pkg::word_t     store_data_i,
    input  rv_pkg::word_t     target_i,
    input  rv_pkg::reg_addr_t dest_addr_i,
    input  wire               dest_we_i,
    input  wire               valid_i,
    output logic              redirect_o,
    output rv_pkg::word_t     redirect_pc_o,
    output rv_pkg::word_t     result_o,
    output rv_pkg::reg_addr_t dest_addr_o,
    output logic              dest_we_o,
    output rv_pkg::mem_req_t  mem_req_o,
    output rv_pkg::word_t     mem_wdata_o
);

    rv_pkg::word_t    alu_res, res;
    rv_pkg::mem_req_t req;
    logic [1:0]       len;
    logic             eq, lt_s, lt_u, take;

    assign eq   = operand_a_i == operand_b_i;
    assign lt_s = $signed(operand_a_i) < $signed(operand_b_i);
    assign lt_u = operand_a_i < operand_b_i;

    always_comb begin
        case (funct3_i)
            // bit 30 selects sub for register ops only
            rv_pkg::F3_ADD:  alu_res = (op_i == rv_pkg::OP_REG && alt_i) ?
                                       operand_a_i - operand_b_i : operand_a_i + operand_b_i;
            rv_pkg::F3_SLL:  alu_res = operand_a_i << operand_b_i[4:0];
            rv_pkg::F3_SLT:  alu_res = {31'b0, lt_s};
            rv_pkg::F3_SLTU: alu_res = {31'b0, lt_u};
            rv_pkg::F3_XOR:  alu_res = operand_a_i ^ operand_b_i;
            rv_pkg::F3_SR: begin
                if (alt_i) begin
                    alu_res = $signed(operand_a_i) >>> operand_b_i[4:0];
                end else begin
                    alu_res = operand_a_i >> operand_b_i[4:0];
                end
            end
            rv_pkg::F3_OR:   alu_res = operand_a_i | operand_b_i;
            default:         alu_res = operand_a_i & operand_b_i;
        endcase
    end

    // branch conditions
    always_comb begin
        case (funct3_i)
            rv_pkg::F3_BEQ:  take = eq;
            rv_pkg::F3_BNE:  take = !eq;
            rv_pkg::F3_BLT:  take = lt_s;
            rv_pkg::F3_BGE:  take = !lt_s;
            rv_pkg::F3_BLTU: take = lt_u;
            rv_pkg::F3_BGEU: take = !lt_u;
            default:         take = 1'b0;
        endcase
    end

    assign len = (funct3_i[1:0] == 2'b00) ? rv_pkg::MEM_LEN_BYTE :
                 (funct3_i[1:0] == 2'b01) ? rv_pkg::MEM_LEN_HALF : rv_pkg::MEM_LEN_WORD;

    always_comb begin
        res = operand_b_i;
        req = '0;
        case (op_i)
            rv_pkg::OP_IMM, rv_pkg::OP_REG: res = alu_res;
            rv_pkg::OP_LOAD: begin
                res = operand_a_i + operand_b_i;
                req = {1'b1, len, 1'b0, funct3_i[2]};
            end
            rv_pkg::OP_STORE: begin
                res = operand_a_i + target_i;
                req = {1'b1, len, 1'b1, 1'b0};
            end
            rv_pkg::OP_BRANCH: res = '0;
            // lui, auipc and the link of jal/jalr come ready in operand b
            default: ;
        endcase
        if (!valid_i) begin
            req = '0;
        end
    end

    assign redirect_o    = valid_i && (op_i == rv_pkg::OP_JAL || op_i == rv_pkg::OP_JALR ||
                                       (op_i == rv_pkg::OP_BRANCH && take));
    assign redirect_pc_o = target_i;

    // execute/memory register
    always_ff @(posedge clk) begin
        result_o    <= res;
        dest_addr_o <= dest_addr_i;
        mem_wdata_o <= store_data_i;
        if (rst) begin
            dest_we_o <= 1'b0;
            mem_req_o <= '0;
        end else begin
            dest_we_o <= valid_i && dest_we_i;
            mem_req_o <= req;
        end
    end

    // the squashed slot behind a control transfer neither jumps nor reaches data memory
    assert property (@(posedge clk) disable iff (rst)
        redirect_o |=> !(redirect_o || req[rv_pkg::MEM_EN_BIT]));

endmodule

`default_nettype wire

// ==== decode/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire               clk,
    input  wire               rst,
    input  rv_pkg::word_t     instr_i,
    input  rv_pkg::word_t     pc_i,
    input  wire               valid_i,
    input  wire               flush_i,
    input  rv_pkg::word_t     rf_rs1_data_i,
    input  rv_pkg::word_t     rf_rs2_data_i,
    output rv_pkg::reg_addr_t rf_rs1_addr_o,
    output rv_pkg::reg_addr_t rf_rs2_addr_o,
    output rv_pkg::opcode_t   op_o,
    output rv_pkg::funct3_t   funct3_o,
    output logic              alt_o,
    output rv_pkg::word_t     operand_a_o,
    output rv_pkg::word_t     operand_b_o,
    output rv_pkg::word_t     store_data_o,
    output rv_pkg::word_t     target_o,
    output rv_pkg::reg_addr_t dest_addr_o,
    output logic              dest_we_o,
    output logic              valid_o
);

    rv_pkg::opcode_t   opcode;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::word_t     op_b, tgt;
    logic              we;

    assign opcode        = instr_i[6:0];
    assign rd            = instr_i[11:7];
    assign rf_rs1_addr_o = instr_i[19:15];
    assign rf_rs2_addr_o = instr_i[24:20];

    // immediate formats
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        // branch and reg defaults
        op_b = rf_rs2_data_i;
        tgt  = pc_i + imm_b;
        we   = 1'b0;
        case (opcode)
            rv_pkg::OP_LUI: begin
                op_b = imm_u;
                we   = 1'b1;
            end
            rv_pkg::OP_AUIPC: begin
                op_b = pc_i + imm_u;
                we   = 1'b1;
            end
            rv_pkg::OP_IMM, rv_pkg::OP_LOAD: begin
                op_b = imm_i;
                we   = 1'b1;
            end
            rv_pkg::OP_REG: we = 1'b1;
            rv_pkg::OP_JAL: begin
                op_b = pc_i + 32'd4;
                tgt  = pc_i + imm_j;
                we   = 1'b1;
            end
            rv_pkg::OP_JALR: begin
                op_b = pc_i + 32'd4;
                tgt  = (rf_rs1_data_i + imm_i) & ~32'd1;
                we   = 1'b1;
            end
            // store offset rides in target
            rv_pkg::OP_STORE: tgt = imm_s;
            default: ;
        endcase
        if (rd == '0) begin
            we = 1'b0;
        end
    end

    // decode/execute register
    always_ff @(posedge clk) begin
        op_o         <= opcode;
        funct3_o     <= instr_i[14:12];
        alt_o        <= instr_i[30];
        operand_a_o  <= rf_rs1_data_i;
        operand_b_o  <= op_b;
        store_data_o <= rf_rs2_data_i;
        target_o     <= tgt;
        dest_addr_o  <= rd;
        dest_we_o    <= we;
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i && !flush_i;
        end
    end

endmodule

`default_nettype wire

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire               clk,
    input  wire               rst,
    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    input  wire               we_i,
    input  rv_pkg::reg_addr_t wd_addr_i,
    input  rv_pkg::word_t     wd_data_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wd_addr_i != '0) begin
            regs[wd_addr_i] <= wd_data_i;
        end
    end

    // bypass the write port so a reader three slots behind sees the value
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (we_i && wd_addr_i == rs1_addr_i) ? wd_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (we_i && wd_addr_i == rs2_addr_i) ? wd_data_i : regs[rs2_addr_i];

endmodule

`default_nettype wire

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire           clk,
    input  wire           rst,
    input  wire           redirect_i,
    input  rv_pkg::word_t redirect_pc_i,
    input  rv_pkg::word_t imem_data_i,
    output rv_pkg::word_t imem_addr_o,
    output rv_pkg::word_t instr_o,
    output rv_pkg::word_t pc_o,
    output logic          valid_o
);

    rv_pkg::word_t pc_q;

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // fetch/decode register, the word fetched this cycle is wrong on redirect
    always_ff @(posedge clk) begin
        instr_o <= imem_data_i;
        pc_o    <= pc_q;
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= !redirect_i;
        end
    end

    // redirect targets from execute must keep the pc on a word boundary
    assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // widths fixed by the ISA
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // memory request: {enable, length[1:0], write, unsigned}
    typedef logic [4:0]  mem_req_t;

    localparam int MEM_EN_BIT  = 4;
    localparam int MEM_LEN_LSB = 2;
    localparam int MEM_WR_BIT  = 1;
    localparam int MEM_UNS_BIT = 0;

    localparam logic [1:0] MEM_LEN_BYTE = 2'd0;
    localparam logic [1:0] MEM_LEN_HALF = 2'd1;
    localparam logic [1:0] MEM_LEN_WORD = 2'd3;

    // major opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;

    // alu funct3
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

endpackage

`default_nettype wire
